//--- hdl/rvcPkg.sv
package rvcPkg;

    localparam int RegAddrWidth = 4;   // Embedded core, x0-x15 only
    localparam int ImmWidth     = 32;
    localparam int NumOps       = 19;

    // One 16-bit word, read through two register field layouts
    typedef union packed {
        struct packed {
            logic [2:0] funct3;
            logic       bit12;
            logic [4:0] rd;     // Also rs1
            logic [4:0] rs2;
            logic [1:0] quad;
        } wide;
        struct packed {
            logic [2:0] funct3;
            logic       bit12;
            logic [1:0] funct2;    // Bits 11:10, ALU group select
            logic [2:0] rs1;       // Maps to x8-x15
            logic [1:0] funct2Lo;  // Bits 6:5, register-register opcode
            logic [2:0] rs2;       // Maps to x8-x15
            logic [1:0] quad;
        } compact;
    } rvcInstr_t;

    // Bit positions in the one-hot operation vector
    typedef enum logic [4:0] {
        OpJ,
        OpJal,
        OpJr,
        OpJalrEbreak,   // EBREAK when rs1 is x0
        OpBeqzBnez,
        OpLw,
        OpSw,
        OpLwsp,
        OpSwsp,
        OpAluMain,
        OpAndi,
        OpSraiSrli,
        OpAddiNop,
        OpSlli,
        OpLiLui,        // Same control row, immediate tells them apart
        OpMv,
        OpAdd,
        OpAddi4spn,
        OpAddi16sp
    } rvcOp_e;

    typedef logic [NumOps-1:0] rvcOpVec_t;  // All zero for an unknown word

    typedef enum logic [1:0] {
        AluBitwise = 2'b00,
        AluAddSub  = 2'b01,
        AluShift   = 2'b10,
        AluFlag    = 2'b11
    } aluCat_e;

    // Bitwise opcodes, 00 unused
    localparam logic [1:0] BtXor  = 2'b01;
    localparam logic [1:0] BtOr   = 2'b10;
    localparam logic [1:0] BtAnd  = 2'b11;
    // Add/sub and flag opcodes
    localparam logic [1:0] AfSubS = 2'b00;
    localparam logic [1:0] AfAdd  = 2'b01;
    localparam logic [1:0] AfSubU = 2'b10;
    localparam logic [1:0] AfEqu  = 2'b11;
    // Shift opcodes, 01 unused
    localparam logic [1:0] ShSll  = 2'b00;
    localparam logic [1:0] ShSrl  = 2'b10;
    localparam logic [1:0] ShSra  = 2'b11;

    typedef enum logic [1:0] {
        PcInc     = 2'b00,
        PcBranch  = 2'b01,
        PcJumpReg = 2'b10,
        PcJumpImm = 2'b11
    } pcMode_e;

    typedef enum logic [1:0] {
        LsuNone = 2'b00,
        LsuWord = 2'b01,
        LsuHalf = 2'b10,
        LsuByte = 2'b11
    } lsuWidth_e;

    localparam logic [RegAddrWidth-1:0] RegZero  = 4'd0;
    localparam logic [RegAddrWidth-1:0] RegLink  = 4'd1;   // ra
    localparam logic [RegAddrWidth-1:0] RegStack = 4'd2;   // sp

endpackage

//--- hdl/rvcClassify.sv
module rvcClassify import rvcPkg::*; (
    input  rvcInstr_t instr,
    output rvcOpVec_t ops
);

    logic [3:0] opMain;     // {quadrant, funct3[2:1]}
    logic [1:0] opJumpAlu;  // {rs2 field zero, bit 12}
    logic       f3Lsb;      // funct3 bit 0, instruction bit 13
    logic       rdIsSp;

    assign opMain    = {instr.wide.quad, instr.wide.funct3[2:1]};
    assign opJumpAlu = {instr.wide.rs2 == 5'd0, instr.wide.bit12};
    assign f3Lsb     = instr.wide.funct3[0];
    assign rdIsSp    = instr.wide.rd == 5'(RegStack);

    always_comb begin
        ops = '0;  // Nothing raised for quadrant 3 or reserved slots
        case (opMain)
            // Quadrant 0
            4'b00_00: ops[OpAddi4spn] = 1'b1;
            4'b00_01: ops[OpLw] = 1'b1;
            4'b00_11: ops[OpSw] = 1'b1;
            // Quadrant 1
            4'b01_00: begin
                if (f3Lsb) ops[OpJal] = 1'b1;
                else       ops[OpAddiNop] = 1'b1;  // NOP is ADDI x0
            end
            4'b01_01: begin
                // LUI with rd == sp is ADDI16SP instead
                if (f3Lsb && rdIsSp) ops[OpAddi16sp] = 1'b1;
                else                 ops[OpLiLui] = 1'b1;
            end
            4'b01_10: begin
                if (f3Lsb) begin
                    ops[OpJ] = 1'b1;
                end else begin
                    case (instr.compact.funct2)
                        2'b11:   ops[OpAluMain] = 1'b1;   // SUB/XOR/OR/AND
                        2'b10:   ops[OpAndi] = 1'b1;
                        default: ops[OpSraiSrli] = 1'b1;  // Bit 10 picks SRA
                    endcase
                end
            end
            4'b01_11: ops[OpBeqzBnez] = 1'b1;  // Bit 13 picks BNEZ
            // Quadrant 2
            4'b10_00: ops[OpSlli] = 1'b1;
            4'b10_01: ops[OpLwsp] = 1'b1;
            4'b10_10: begin
                case (opJumpAlu)
                    2'b00: ops[OpMv] = 1'b1;
                    2'b01: ops[OpAdd] = 1'b1;
                    2'b10: ops[OpJr] = 1'b1;
                    2'b11: ops[OpJalrEbreak] = 1'b1;
                endcase
            end
            4'b10_11: ops[OpSwsp] = 1'b1;
            default: ;  // Reserved 00_10 and all of quadrant 3
        endcase
    end

endmodule

//--- hdl/rvcImmediate.sv
module rvcImmediate import rvcPkg::*; (
    input  rvcInstr_t            instr,
    input  rvcOpVec_t            ops,
    output logic [ImmWidth-1:0] imm
);

    logic [15:0] i;  // Flat bits, the formats scramble across both views
    logic fmtA;      // ANDI, ADDI, LI: signed 6 bit
    logic fmtB;      // LWSP
    logic fmtC;      // J, JAL
    logic fmtD;      // Branch offset
    logic fmtE;      // ADDI16SP, scaled by 16
    logic fmtF;      // ADDI4SPN, scaled by 4
    logic fmtG;      // LW, SW
    logic fmtH;      // SWSP
    logic fmtI;      // Shift amount, unsigned
    logic fmtLui;    // Upper bits 17:12
    logic fmtAI;
    logic signLow;
    logic signHigh;

    assign i = instr;

    assign fmtA   = ops[OpAndi] | ops[OpAddiNop] | (ops[OpLiLui] & ~instr.wide.funct3[0]);
    assign fmtB   = ops[OpLwsp];
    assign fmtC   = ops[OpJ] | ops[OpJal];
    assign fmtD   = ops[OpBeqzBnez];
    assign fmtE   = ops[OpAddi16sp];
    assign fmtF   = ops[OpAddi4spn];
    assign fmtG   = ops[OpLw] | ops[OpSw];
    assign fmtH   = ops[OpSwsp];
    assign fmtI   = ops[OpSraiSrli] | ops[OpSlli];
    assign fmtLui = ops[OpLiLui] & instr.wide.funct3[0];  // LUI half of the pair
    assign fmtAI  = fmtA | fmtI;  // Same low bits, only extension differs

    // Bit 12 is the sign for every signed format
    assign signLow  = instr.wide.bit12 & (fmtA | fmtC | fmtD | fmtE);
    assign signHigh = signLow | (instr.wide.bit12 & fmtLui);

    // Each bit is an OR over the formats that feed it
    assign imm[0]  = i[2] & fmtAI;
    assign imm[1]  = i[3] & (fmtAI | fmtC | fmtD);
    assign imm[2]  = (i[4] & (fmtAI | fmtB | fmtC | fmtD)) | (i[9] & fmtH)
                   | (i[6] & (fmtF | fmtG));
    assign imm[3]  = (i[5] & (fmtAI | fmtB | fmtC | fmtF)) | (i[10] & (fmtD | fmtG | fmtH));
    assign imm[4]  = (i[6] & (fmtAI | fmtB | fmtE))
                   | (i[11] & (fmtC | fmtD | fmtF | fmtG | fmtH));
    assign imm[5]  = (i[12] & (fmtAI | fmtB | fmtF | fmtG | fmtH)) | (i[2] & (fmtC | fmtD | fmtE));
    assign imm[6]  = (i[12] & fmtA) | (i[5] & (fmtD | fmtE | fmtG)) | (i[2] & fmtB)
                   | (i[7] & (fmtC | fmtF | fmtH));
    assign imm[7]  = (i[12] & fmtA) | (i[6] & (fmtC | fmtD)) | (i[3] & (fmtB | fmtE))
                   | (i[8] & (fmtF | fmtH));
    assign imm[8]  = (i[12] & (fmtA | fmtD)) | (i[4] & fmtE) | (i[9] & (fmtC | fmtF));
    assign imm[9]  = (i[12] & (fmtA | fmtD | fmtE)) | (i[10] & (fmtC | fmtF));
    assign imm[10] = (i[12] & (fmtA | fmtD | fmtE)) | (i[8] & fmtC);
    assign imm[11] = signLow;
    assign imm[16:12] = fmtLui ? i[6:2] : {5{signLow}};  // LUI payload lands here
    assign imm[ImmWidth-1:17] = {(ImmWidth-17){signHigh}};

endmodule

//--- hdl/rvcControl.sv
module rvcControl import rvcPkg::*; (
    input  rvcInstr_t                instr,
    input  rvcOpVec_t                ops,
    output logic [RegAddrWidth-1:0] rs1,
    output logic [RegAddrWidth-1:0] rs2,
    output logic [RegAddrWidth-1:0] rd,
    output logic                     lsuLoad,     // Load when set, else store
    output logic                     lsuSignExt,
    output lsuWidth_e                lsuWidth,
    output logic                     multiCycle,  // Load unit writes rd later
    output logic                     aluImm,      // ALU operand B from immediate
    output aluCat_e                  aluCat,
    output logic [1:0]               aluOp,
    output logic                     flagInv,
    output logic                     pcWriteback, // Link address to rd
    output pcMode_e                  pcMode,
    output logic                     legal
);

    logic                    useWide;
    logic [RegAddrWidth-1:0] rawRs1;
    logic [RegAddrWidth-1:0] rawRs2;
    logic [RegAddrWidth-1:0] rawRd;

    // Quadrant 2 and the low half of quadrant 1 carry full register fields
    assign useWide = instr.wide.quad[1] | (instr.wide.quad[0] & ~instr.wide.funct3[2]);
    assign rawRs1  = useWide ? instr.wide.rd[RegAddrWidth-1:0] : {1'b1, instr.compact.rs1};
    assign rawRs2  = useWide ? instr.wide.rs2[RegAddrWidth-1:0] : {1'b1, instr.compact.rs2};
    assign rawRd   = (ops[OpLw] | ops[OpAddi4spn]) ? rawRs2 : rawRs1;  // rd sits in rs2 slot

    assign legal = |ops;

    always_comb begin
        rs1         = rawRs1;
        rs2         = rawRs2;
        rd          = rawRd;
        lsuLoad     = 1'b0;  // Zero row doubles as the illegal word output
        lsuSignExt  = 1'b0;
        lsuWidth    = LsuNone;
        multiCycle  = 1'b0;
        aluImm      = 1'b0;
        aluCat      = AluBitwise;
        aluOp       = 2'b00;
        flagInv     = 1'b0;
        pcWriteback = 1'b0;
        pcMode      = PcInc;
        unique case (1'b1)
            ops[OpAluMain]: begin
                case (instr.compact.funct2Lo)
                    2'b00: begin aluCat = AluAddSub;  aluOp = AfSubS; end
                    2'b01: begin aluCat = AluBitwise; aluOp = BtXor;  end
                    2'b10: begin aluCat = AluBitwise; aluOp = BtOr;   end
                    2'b11: begin aluCat = AluBitwise; aluOp = BtAnd;  end
                endcase
            end
            ops[OpAndi]: begin
                aluImm = 1'b1;
                aluOp  = BtAnd;
            end
            ops[OpSraiSrli]: begin
                aluImm = 1'b1;
                aluCat = AluShift;
                aluOp  = instr.compact.funct2[0] ? ShSra : ShSrl;  // Bit 10
            end
            ops[OpSlli]: begin
                aluImm = 1'b1;
                aluCat = AluShift;
                aluOp  = ShSll;
            end
            ops[OpAddiNop], ops[OpAddi16sp]: begin
                aluImm = 1'b1;
                aluCat = AluAddSub;
                aluOp  = AfAdd;
            end
            ops[OpAdd]: begin aluCat = AluAddSub; aluOp = AfAdd; end
            ops[OpLiLui], ops[OpMv]: begin
                aluImm = ops[OpLiLui];  // Move takes rs2 instead
                aluOp  = BtOr;          // x0 | operand passes straight through
                rs1    = RegZero;
            end
            ops[OpAddi4spn]: begin
                aluImm = 1'b1;
                aluCat = AluAddSub;
                aluOp  = AfAdd;
                rs1    = RegStack;
            end
            ops[OpJ], ops[OpJal]: begin
                pcMode      = PcJumpImm;   // Immediate goes to the PC adder, ALU idle
                pcWriteback = ops[OpJal];
                rd          = ops[OpJal] ? RegLink : RegZero;
            end
            ops[OpJr], ops[OpJalrEbreak]: begin
                aluCat      = AluAddSub;
                aluOp       = AfAdd;
                pcMode      = PcJumpReg;
                pcWriteback = ops[OpJalrEbreak];
                rd          = ops[OpJalrEbreak] ? RegLink : RegZero;
            end
            ops[OpBeqzBnez]: begin
                aluCat  = AluFlag;
                aluOp   = AfEqu;               // Compare rs1 against x0
                flagInv = instr.wide.funct3[0]; // BNEZ
                pcMode  = PcBranch;
                rs2     = RegZero;
                rd      = RegZero;
            end
            ops[OpLw], ops[OpLwsp]: begin
                lsuLoad    = 1'b1;
                lsuWidth   = LsuWord;
                multiCycle = 1'b1;
                aluImm     = 1'b1;  // ALU forms the address
                aluCat     = AluAddSub;
                aluOp      = AfAdd;
            end
            ops[OpSw], ops[OpSwsp]: begin
                lsuWidth = LsuWord;
                aluImm   = 1'b1;  // rs2 still feeds the store data
                aluCat   = AluAddSub;
                aluOp    = AfAdd;
                rd       = RegZero;
                if (ops[OpSwsp]) rs1 = RegStack;
            end
            default: ;  // Unknown word keeps the zero row
        endcase
    end

endmodule

//--- hdl/rvcResultStage.sv
module rvcResultStage import rvcPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    inValid,
    output logic                    inReady,
    output logic                    outValid,
    input  logic                    outReady,
    input  logic [RegAddrWidth-1:0] rs1, rs2, rd,
    input  logic [ImmWidth-1:0]     imm,
    input  logic                    lsuLoad, lsuSignExt, multiCycle, aluImm,
    input  lsuWidth_e               lsuWidth,
    input  aluCat_e                 aluCat,
    input  logic [1:0]              aluOp,
    input  logic                    flagInv, pcWriteback, legal,
    input  pcMode_e                 pcMode,
    output logic [RegAddrWidth-1:0] rs1Q, rs2Q, rdQ,
    output logic [ImmWidth-1:0]     immQ,
    output logic                    lsuLoadQ, lsuSignExtQ, multiCycleQ, aluImmQ,
    output lsuWidth_e               lsuWidthQ,
    output aluCat_e                 aluCatQ,
    output logic [1:0]              aluOpQ,
    output logic                    flagInvQ, pcWritebackQ, legalQ,
    output pcMode_e                 pcModeQ
);

    logic accept;

    assign inReady = ~outValid | outReady;  // Empty, or draining this edge
    assign accept  = inValid & inReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid     <= 1'b0;
            lsuLoadQ     <= 1'b0;
            lsuSignExtQ  <= 1'b0;
            lsuWidthQ    <= LsuNone;
            multiCycleQ  <= 1'b0;
            aluImmQ      <= 1'b0;
            aluCatQ      <= AluBitwise;
            aluOpQ       <= 2'b00;
            flagInvQ     <= 1'b0;
            pcWritebackQ <= 1'b0;
            pcModeQ      <= PcInc;
            legalQ       <= 1'b0;
        end else begin
            if (inReady) outValid <= inValid;  // Held while stalled
            if (accept) begin
                lsuLoadQ     <= lsuLoad;
                lsuSignExtQ  <= lsuSignExt;
                lsuWidthQ    <= lsuWidth;
                multiCycleQ  <= multiCycle;
                aluImmQ      <= aluImm;
                aluCatQ      <= aluCat;
                aluOpQ       <= aluOp;
                flagInvQ     <= flagInv;
                pcWritebackQ <= pcWriteback;
                pcModeQ      <= pcMode;
                legalQ       <= legal;
            end
        end
    end

    // Register addresses and immediate, loaded on every accept
    always_ff @(posedge clk) begin
        if (accept) begin
            rs1Q <= rs1;
            rs2Q <= rs2;
            rdQ  <= rd;
            immQ <= imm;
        end
    end

endmodule

//--- hdl/rvcDecoder.sv
module rvcDecoder import rvcPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    inValid,
    output logic                    inReady,
    input  logic [15:0]             instr,
    output logic                    outValid,
    input  logic                    outReady,
    output logic [RegAddrWidth-1:0] rs1, rs2, rd,
    output logic [ImmWidth-1:0]     imm,
    output logic                    lsuLoad, lsuSignExt, multiCycle, aluImm,
    output lsuWidth_e               lsuWidth,
    output aluCat_e                 aluCat,
    output logic [1:0]              aluOp,
    output logic                    flagInv, pcWriteback, legal,
    output pcMode_e                 pcMode
);

    rvcInstr_t               word;
    rvcOpVec_t               ops;
    logic [RegAddrWidth-1:0] decRs1, decRs2, decRd;
    logic [ImmWidth-1:0]     decImm;
    logic                    decLsuLoad, decLsuSignExt, decMultiCycle, decAluImm;
    lsuWidth_e               decLsuWidth;
    aluCat_e                 decAluCat;
    logic [1:0]              decAluOp;
    logic                    decFlagInv, decPcWriteback, decLegal;
    pcMode_e                 decPcMode;

    assign word = instr;

    rvcClassify classify_i (.instr(word), .ops(ops));

    rvcImmediate immediate_i (.instr(word), .ops(ops), .imm(decImm));

    rvcControl control_i (
        .instr(word), .ops(ops), .rs1(decRs1), .rs2(decRs2), .rd(decRd),
        .lsuLoad(decLsuLoad), .lsuSignExt(decLsuSignExt), .lsuWidth(decLsuWidth),
        .multiCycle(decMultiCycle), .aluImm(decAluImm), .aluCat(decAluCat),
        .aluOp(decAluOp), .flagInv(decFlagInv), .pcWriteback(decPcWriteback),
        .pcMode(decPcMode), .legal(decLegal)
    );

    // One cycle from accept to outValid
    rvcResultStage resultStage_i (
        .clk(clk), .reset(reset), .inValid(inValid), .inReady(inReady),
        .outValid(outValid), .outReady(outReady),
        .rs1(decRs1), .rs2(decRs2), .rd(decRd), .imm(decImm),
        .lsuLoad(decLsuLoad), .lsuSignExt(decLsuSignExt), .multiCycle(decMultiCycle),
        .aluImm(decAluImm), .lsuWidth(decLsuWidth), .aluCat(decAluCat),
        .aluOp(decAluOp), .flagInv(decFlagInv), .pcWriteback(decPcWriteback),
        .legal(decLegal), .pcMode(decPcMode),
        .rs1Q(rs1), .rs2Q(rs2), .rdQ(rd), .immQ(imm),
        .lsuLoadQ(lsuLoad), .lsuSignExtQ(lsuSignExt), .multiCycleQ(multiCycle),
        .aluImmQ(aluImm), .lsuWidthQ(lsuWidth), .aluCatQ(aluCat), .aluOpQ(aluOp),
        .flagInvQ(flagInv), .pcWritebackQ(pcWriteback), .legalQ(legal),
        .pcModeQ(pcMode)
    );

endmodule

//--- tests/rvcDecoder_properties.sv
module rvcDecoderProperties import rvcPkg::*; (
    input logic                    clk,
    input logic                    reset,
    input logic                    outValid,
    input logic                    outReady,
    input logic [RegAddrWidth-1:0] rs1, rs2, rd,
    input logic [ImmWidth-1:0]     imm,
    input logic                    lsuLoad, lsuSignExt, multiCycle, aluImm,
    input lsuWidth_e               lsuWidth,
    input aluCat_e                 aluCat,
    input logic [1:0]              aluOp,
    input logic                    flagInv, pcWriteback, legal,
    input pcMode_e                 pcMode
);

    logic [13:0] ctlWord;  // Registered control fields
    logic [58:0] outWord;  // Everything the consumer samples

    assign ctlWord = {lsuLoad, lsuSignExt, lsuWidth, multiCycle, aluImm, aluCat, aluOp,
                      flagInv, pcWriteback, pcMode};
    assign outWord = {rs1, rs2, rd, imm, ctlWord, legal};

    stallHold: assert property (@(posedge clk) disable iff (reset)
        outValid && !outReady |=> outValid && $stable(outWord))
        else $error("Outputs changed while stalled");

    resetClears: assert property (@(posedge clk) reset |=> !outValid)
        else $error("outValid high in the cycle after reset");

    // Unknown words leave the zero control row
    illegalZero: assert property (@(posedge clk) disable iff (reset) !legal |-> ctlWord == '0)
        else $error("Control fields nonzero with legal low");

endmodule

bind rvcDecoder rvcDecoderProperties props_i (.*);

//--- tests/rvcDecoderTb.sv
module rvcDecoderTb import rvcPkg::*; ();

    logic                    clk;
    logic                    reset;
    logic                    inValid;
    logic                    inReady;
    logic [15:0]             instr;
    logic                    outValid;
    logic                    outReady;
    logic [RegAddrWidth-1:0] rs1, rs2, rd;
    logic [ImmWidth-1:0]     imm;
    logic                    lsuLoad, lsuSignExt, multiCycle, aluImm;
    lsuWidth_e               lsuWidth;
    aluCat_e                 aluCat;
    logic [1:0]              aluOp;
    logic                    flagInv, pcWriteback, legal;
    pcMode_e                 pcMode;

    // Reference model outputs for the word at the head of the queue
    logic [3:0]  eRs1, eRs2, eRd;
    logic [31:0] eImm;
    logic [1:0]  eWidth, eCat, eOp, ePc;
    logic        eLoad, eMulti, eAluImm, eInv, eWb, eLegal;

    integer      seed;
    logic [15:0] pending[$];     // Accepted, not yet seen at the output
    int          errors = 0;
    int          checked = 0;
    int          sent;
    int          stallLevel;     // Chance of outReady low, out of 256
    logic        timedOut;

    rvcDecoder dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic setAlu(input logic useImm, input logic [1:0] cat, input logic [1:0] op);
        eAluImm = useImm;
        eCat    = cat;
        eOp     = op;
    endtask

    // Word access, address is rs1 plus offset
    task automatic setMem(input logic load);
        eLoad  = load;
        eMulti = load;       // Load result comes back later
        eWidth = LsuWord;
        setAlu(1'b1, AluAddSub, AfAdd);
    endtask

    task automatic modelDecode(input logic [15:0] w);
        logic        wideView;
        logic [3:0]  vRs1;
        logic [3:0]  vRs2;
        logic [31:0] sImm6;
        wideView = w[1] | (w[0] & ~w[15]);  // Quadrant 2, or quadrant 1 low half
        vRs1  = wideView ? w[10:7] : {1'b1, w[9:7]};
        vRs2  = wideView ? w[5:2] : {1'b1, w[4:2]};
        sImm6 = {{26{w[12]}}, w[12], w[6:2]};
        eRs1  = vRs1;
        eRs2  = vRs2;
        eRd   = vRs1;
        eImm  = '0;
        {eLoad, eMulti, eInv, eWb, eWidth, ePc} = '0;
        setAlu(1'b0, 2'b00, 2'b00);
        eLegal = 1'b1;
        casez ({w[1:0], w[15:13]})
            5'b00_00?: begin  // ADDI4SPN, rd sits in the rs2 slot
                setAlu(1'b1, AluAddSub, AfAdd);
                eRs1 = RegStack;
                eRd  = vRs2;
                eImm = {22'd0, w[10:7], w[12:11], w[5], w[6], 2'b00};
            end
            5'b00_01?: begin  // LW
                setMem(1'b1);
                eRd  = vRs2;
                eImm = {25'd0, w[5], w[12:10], w[6], 2'b00};
            end
            5'b00_11?: begin  // SW
                setMem(1'b0);
                eRd  = RegZero;
                eImm = {25'd0, w[5], w[12:10], w[6], 2'b00};
            end
            5'b01_000: begin
                setAlu(1'b1, AluAddSub, AfAdd);  // ADDI and NOP
                eImm = sImm6;
            end
            5'b01_?01: begin  // JAL with bit 15 clear, J with it set
                ePc  = PcJumpImm;
                eWb  = ~w[15];
                eRd  = w[15] ? RegZero : RegLink;
                eImm = {{20{w[12]}}, w[12], w[8], w[10:9], w[6], w[7], w[2], w[11],
                        w[5:3], 1'b0};
            end
            5'b01_010: begin
                setAlu(1'b1, AluBitwise, BtOr);  // LI is x0 OR imm
                eRs1 = RegZero;
                eImm = sImm6;
            end
            5'b01_011: begin
                if (w[11:7] == 5'd2) begin  // ADDI16SP, scaled by 16
                    setAlu(1'b1, AluAddSub, AfAdd);
                    eImm = {{23{w[12]}}, w[4:3], w[5], w[2], w[6], 4'd0};
                end else begin              // LUI
                    setAlu(1'b1, AluBitwise, BtOr);
                    eRs1 = RegZero;
                    eImm = {{15{w[12]}}, w[6:2], 12'd0};
                end
            end
            5'b01_100: begin
                if (w[11:10] == 2'b11) begin
                    case (w[6:5])  // SUB, XOR, OR, AND
                        2'b00:   setAlu(1'b0, AluAddSub, AfSubS);
                        2'b01:   setAlu(1'b0, AluBitwise, BtXor);
                        2'b10:   setAlu(1'b0, AluBitwise, BtOr);
                        default: setAlu(1'b0, AluBitwise, BtAnd);
                    endcase
                end else if (w[11:10] == 2'b10) begin
                    setAlu(1'b1, AluBitwise, BtAnd);  // ANDI
                    eImm = sImm6;
                end else begin
                    setAlu(1'b1, AluShift, w[10] ? ShSra : ShSrl);
                    eImm = {26'd0, w[12], w[6:2]};    // Shift amount, no sign
                end
            end
            5'b01_11?: begin  // BEQZ, BNEZ
                setAlu(1'b0, AluFlag, AfEqu);
                eInv = w[13];
                ePc  = PcBranch;
                eRs2 = RegZero;
                eRd  = RegZero;
                eImm = {{23{w[12]}}, w[12], w[6:5], w[2], w[11:10], w[4:3], 1'b0};
            end
            5'b10_00?: begin
                setAlu(1'b1, AluShift, ShSll);
                eImm = {26'd0, w[12], w[6:2]};
            end
            5'b10_01?: begin  // LWSP
                setMem(1'b1);
                eImm = {24'd0, w[3:2], w[12], w[6:4], 2'b00};
            end
            5'b10_10?: begin
                if (w[6:2] != 5'd0) begin  // MV or ADD
                    setAlu(1'b0, w[12] ? AluAddSub : AluBitwise, w[12] ? AfAdd : BtOr);
                    if (!w[12]) eRs1 = RegZero;
                end else begin             // JR or JALR
                    setAlu(1'b0, AluAddSub, AfAdd);
                    ePc = PcJumpReg;
                    eWb = w[12];
                    eRd = w[12] ? RegLink : RegZero;
                end
            end
            5'b10_11?: begin  // SWSP
                setMem(1'b0);
                eRs1 = RegStack;
                eRd  = RegZero;
                eImm = {24'd0, w[8:7], w[12:9], 2'b00};
            end
            default: eLegal = 1'b0;  // Reserved quadrant 0 slot, all of quadrant 3
        endcase
    endtask

    task automatic checkField(input string name, input logic [31:0] got,
                              input logic [31:0] exp, input logic [15:0] w);
        assert (got === exp) else begin
            $display("ERROR %s: got %h, expected %h, instr %h", name, got, exp, w);
            errors++;
        end
    endtask

    task automatic checkOutput();
        logic [15:0] w;
        assert (pending.size() > 0) else begin
            $display("Output transfer with no accepted word waiting for it");
            errors++;
        end
        if (pending.size() > 0) begin
            w = pending.pop_front();
            modelDecode(w);
            checkField("rs1", 32'(rs1), 32'(eRs1), w);
            checkField("rs2", 32'(rs2), 32'(eRs2), w);
            checkField("rd", 32'(rd), 32'(eRd), w);
            checkField("imm", imm, eImm, w);
            checkField("lsuLoad", 32'(lsuLoad), 32'(eLoad), w);
            checkField("lsuSignExt", 32'(lsuSignExt), 32'd0, w);
            checkField("lsuWidth", 32'(lsuWidth), 32'(eWidth), w);
            checkField("multiCycle", 32'(multiCycle), 32'(eMulti), w);
            checkField("aluImm", 32'(aluImm), 32'(eAluImm), w);
            checkField("aluCat", 32'(aluCat), 32'(eCat), w);
            checkField("aluOp", 32'(aluOp), 32'(eOp), w);
            checkField("flagInv", 32'(flagInv), 32'(eInv), w);
            checkField("pcWriteback", 32'(pcWriteback), 32'(eWb), w);
            checkField("pcMode", 32'(pcMode), 32'(ePc), w);
            checkField("legal", 32'(legal), 32'(eLegal), w);
            checked++;
        end
    endtask

    // Output side, values seen here are the ones before the edge
    always @(posedge clk) begin
        if (!reset && outValid && outReady) checkOutput();
    end

    task automatic tick();
        @(posedge clk);
        outReady <= (($random(seed) & 255) >= stallLevel);  // Random back-pressure
    endtask

    task automatic makeWord(input int quad, output logic [15:0] w);
        w = 16'($random(seed));
        if (quad < 4) w[1:0] = 2'(quad);
        if (($random(seed) & 3) == 0) w[6:2] = 5'd0;   // Reach JR and JALR
        if (($random(seed) & 7) == 0) w[11:7] = 5'd2;  // Reach ADDI16SP
    endtask

    task automatic sendWord(input logic [15:0] w);
        int waitCycles;
        instr   <= w;
        inValid <= 1'b1;
        waitCycles = 0;
        do begin
            tick();
            waitCycles++;
        end while (!inReady && waitCycles < 200);
        if (inReady) begin
            pending.push_back(w);
            sent++;
        end else begin
            timedOut = 1'b1;
            $display("Timed out waiting for inReady");
        end
    endtask

    task automatic drain();
        int waitCycles;
        inValid <= 1'b0;
        waitCycles = 0;
        while (pending.size() != 0 && waitCycles < 500) begin
            tick();
            waitCycles++;
        end
        if (pending.size() != 0) begin
            timedOut = 1'b1;
            $display("Timed out with %0d accepted words still missing", pending.size());
        end
    endtask

    task automatic runTest(input string name, input int quad, input int level, input int count);
        int          errorsBefore;
        int          checkedBefore;
        logic [15:0] w;
        errorsBefore  = errors;
        checkedBefore = checked;
        stallLevel    = level;
        for (int n = 0; n < count && !timedOut; n++) begin
            makeWord(quad, w);
            sendWord(w);
            if (($random(seed) & 3) == 0) begin
                inValid <= 1'b0;  // Bubble between words
                tick();
            end
        end
        if (!timedOut) drain();
        $display("Test %s: %0d words checked, %0d errors", name, checked - checkedBefore,
                 errors - errorsBefore);
    endtask

    initial begin
        seed       = 32'h3478_3d68;
        sent       = 0;
        stallLevel = 64;
        timedOut   = 1'b0;
        reset    <= 1'b1;
        inValid  <= 1'b0;
        instr    <= 16'd0;
        outReady <= 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        runTest("quadrant 0", 0, 64, 400);
        runTest("quadrant 1", 1, 64, 400);
        runTest("quadrant 2", 2, 64, 400);
        runTest("quadrant 3", 3, 64, 100);
        runTest("mixed under back-pressure", 4, 160, 600);  // Any quadrant, heavy stalls
        $display("Summary: %0d words sent, %0d checked, %0d errors", sent, checked, errors);
        if (errors == 0 && !timedOut && sent == checked) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
hdl/rvcPkg.sv
hdl/rvcClassify.sv
hdl/rvcImmediate.sv
hdl/rvcControl.sv
hdl/rvcResultStage.sv
hdl/rvcDecoder.sv
tests/rvcDecoder_properties.sv
tests/rvcDecoderTb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module rvcDecoderTb -f all.f -o rvcDecoderSim

./obj_dir/rvcDecoderSim | tee sim.log

grep -q "^STATUS: PASS$" sim.log
